// File: filelist.f
+incdir+hw
hw/fib_pkg.sv
hw/fib_table_if.sv
hw/prefix_hash.sv
hw/fib_table.sv
hw/fib_learn.sv
hw/fib_lookup.sv
hw/data_forward.sv
hw/fib.sv
testbench/fib_tb.sv

// File: hw/data_forward.sv
/* Data forwarding controller: PIT query for an arriving packet, then a
   fixed-length payload burst on acceptance */

`timescale 1ns/1ns
`default_nettype none

`include "fib_defines.svh"

module data_forward (
    input  logic             clk,
    input  logic             rst,
    input  logic             data_valid,
    input  fib_pkg::prefix_t data_prefix,
    input  fib_pkg::plen_t   data_len,
    output logic             data_ready,
    output logic             pit_query_valid,
    output fib_pkg::prefix_t pit_query_prefix,
    output fib_pkg::plen_t   pit_query_len,
    input  logic             pit_accept,
    input  logic             pit_reject,
    input  logic             payload_valid,
    input  fib_pkg::byte_t   payload_in,
    output logic             out_valid,
    output fib_pkg::byte_t   out_byte,
    output logic             burst_done
);
    localparam int CNT_W = $clog2(`FIB_BURST_BYTES);

    typedef enum logic [1:0] {S_IDLE, S_QUERY, S_WAIT_PIT, S_STREAM} state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    logic             take;
    logic             last_byte;

    assign data_ready = (state == S_IDLE);

    // Query held in both query states
    assign pit_query_valid = (state == S_QUERY) || (state == S_WAIT_PIT);

    // A byte is taken on every valid cycle while streaming
    assign take      = (state == S_STREAM) && payload_valid;
    assign last_byte = (byte_cnt == CNT_W'(`FIB_BURST_BYTES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            byte_cnt   <= '0;
            out_valid  <= 1'b0;
            burst_done <= 1'b0;
        end else begin
            out_valid  <= take;
            burst_done <= take && last_byte;
            case (state)
                S_IDLE: if (data_valid) state <= S_QUERY;
                // First query cycle, PIT may already answer
                S_QUERY, S_WAIT_PIT: begin
                    if (pit_reject) begin
                        state <= S_IDLE;
                    end else if (pit_accept) begin
                        state    <= S_STREAM;
                        byte_cnt <= '0;
                    end else begin
                        state <= S_WAIT_PIT;
                    end
                end
                S_STREAM: begin
                    // Gaps in payload_valid just stall the count
                    if (take) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte) state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Packet name latch, also drives the query fields
    always_ff @(posedge clk) begin
        if (data_valid && data_ready) begin
            pit_query_prefix <= data_prefix;
            pit_query_len    <= data_len;
        end
    end

    // Output byte register
    always_ff @(posedge clk) begin
        if (take) begin
            out_byte <= payload_in;
        end
    end

endmodule

`default_nettype wire

// File: hw/fib.sv
/* FIB top level: hash unit, valid-bit table, learn, lookup and forwarding */

`timescale 1ns/1ns
`default_nettype none

module fib (
    input  logic             clk,
    input  logic             rst,
    // Learn request
    input  logic             learn_valid,
    input  fib_pkg::prefix_t learn_prefix,
    input  fib_pkg::plen_t   learn_len,
    output logic             learn_ready,
    // Lookup request and result
    input  logic             lookup_valid,
    input  fib_pkg::prefix_t lookup_prefix,
    input  fib_pkg::plen_t   lookup_len,
    output logic             lookup_ready,
    output logic             lpm_valid,
    output fib_pkg::prefix_t lpm_prefix,
    output fib_pkg::plen_t   lpm_len,
    // PIT query
    output logic             pit_query_valid,
    output fib_pkg::prefix_t pit_query_prefix,
    output fib_pkg::plen_t   pit_query_len,
    input  logic             pit_accept,
    input  logic             pit_reject,
    // Data arrival and payload
    input  logic             data_valid,
    input  fib_pkg::prefix_t data_prefix,
    input  fib_pkg::plen_t   data_len,
    output logic             data_ready,
    input  logic             payload_valid,
    input  fib_pkg::byte_t   payload_in,
    output logic             out_valid,
    output fib_pkg::byte_t   out_byte,
    output logic             burst_done
);
    import fib_pkg::*;

    // Hash requester 0 is lookup, 1 is learn
    logic [1:0]    hash_req;
    prefix_t [1:0] hash_prefix;
    plen_t [1:0]   hash_len;
    logic [1:0]    hash_grant;
    hidx_t         hash_idx;
    logic          hash_done;
    logic          hash_done_id;

    fib_table_if tbl_if ();

    prefix_hash u_hash (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (hash_req),
        .req_prefix (hash_prefix),
        .req_len    (hash_len),
        .grant      (hash_grant),
        .hash       (hash_idx),
        .done       (hash_done),
        .done_id    (hash_done_id)
    );

    fib_table u_table (.clk(clk), .rst(rst), .tbl(tbl_if.memory));

    fib_learn u_learn (
        .clk          (clk),
        .rst          (rst),
        .learn_valid  (learn_valid),
        .learn_prefix (learn_prefix),
        .learn_len    (learn_len),
        .learn_ready  (learn_ready),
        .hash_req     (hash_req[1]),
        .hash_prefix  (hash_prefix[1]),
        .hash_len     (hash_len[1]),
        .hash_grant   (hash_grant[1]),
        .hash_idx     (hash_idx),
        .hash_done    (hash_done),
        .hash_done_id (hash_done_id),
        .tbl          (tbl_if.learner)
    );

    fib_lookup u_lookup (
        .clk           (clk),
        .rst           (rst),
        .lookup_valid  (lookup_valid),
        .lookup_prefix (lookup_prefix),
        .lookup_len    (lookup_len),
        .lookup_ready  (lookup_ready),
        .hash_req      (hash_req[0]),
        .hash_prefix   (hash_prefix[0]),
        .hash_len      (hash_len[0]),
        .hash_grant    (hash_grant[0]),
        .hash_idx      (hash_idx),
        .hash_done     (hash_done),
        .hash_done_id  (hash_done_id),
        .tbl           (tbl_if.prober),
        .lpm_valid     (lpm_valid),
        .lpm_prefix    (lpm_prefix),
        .lpm_len       (lpm_len)
    );

    data_forward u_forward (
        .clk              (clk),
        .rst              (rst),
        .data_valid       (data_valid),
        .data_prefix      (data_prefix),
        .data_len         (data_len),
        .data_ready       (data_ready),
        .pit_query_valid  (pit_query_valid),
        .pit_query_prefix (pit_query_prefix),
        .pit_query_len    (pit_query_len),
        .pit_accept       (pit_accept),
        .pit_reject       (pit_reject),
        .payload_valid    (payload_valid),
        .payload_in       (payload_in),
        .out_valid        (out_valid),
        .out_byte         (out_byte),
        .burst_done       (burst_done)
    );

endmodule

`default_nettype wire

// File: hw/fib_defines.svh
/* FIB sizing macros: prefix, length and hash index widths, payload burst length */

`ifndef FIB_DEFINES_SVH
`define FIB_DEFINES_SVH

// Name prefix word, MSB first
`define FIB_PREFIX_W 64

// Prefix length field, one table row per length
`define FIB_LEN_W 6

// Column index into one table row
`define FIB_HASH_W 10

// Payload bytes forwarded per accepted data packet
// Kept short so simulation stays quick
`define FIB_BURST_BYTES 16

// Payload byte width
`define FIB_BYTE_W 8

`endif

// File: hw/fib_learn.sv
/* Insert controller: latches an announced prefix, hashes it, sets its valid bit */

`timescale 1ns/1ns
`default_nettype none

module fib_learn (
    input  logic             clk,
    input  logic             rst,
    input  logic             learn_valid,
    input  fib_pkg::prefix_t learn_prefix,
    input  fib_pkg::plen_t   learn_len,
    output logic             learn_ready,
    output logic             hash_req,
    output fib_pkg::prefix_t hash_prefix,
    output fib_pkg::plen_t   hash_len,
    input  logic             hash_grant,
    input  fib_pkg::hidx_t   hash_idx,
    input  logic             hash_done,
    input  logic             hash_done_id,
    fib_table_if.learner     tbl
);
    import fib_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

    state_t  state;
    prefix_t prefix_q;
    plen_t   len_q;
    logic    own_done;

    // This block is requester 1
    assign own_done = hash_done & hash_done_id;

    // No new work during the clear sweep
    assign learn_ready = (state == S_IDLE) && !tbl.busy;

    assign hash_req    = (state == S_REQ);
    assign hash_prefix = prefix_q;
    assign hash_len    = len_q;

    // Bit set on the tagged done pulse
    assign tbl.wr_en  = (state == S_WAIT) && own_done;
    assign tbl.wr_len = len_q;
    assign tbl.wr_idx = hash_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (learn_valid && learn_ready) state <= S_REQ;
                // Request held until the arbiter grants it
                S_REQ:  if (hash_grant) state <= S_WAIT;
                S_WAIT: if (own_done) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Announcement latch
    always_ff @(posedge clk) begin
        if (learn_valid && learn_ready) begin
            prefix_q <= learn_prefix;
            len_q    <= learn_len;
        end
    end

endmodule

`default_nettype wire

// File: hw/fib_lookup.sv
/* Longest-prefix-match controller: hashes and probes the table from the
   requested length downward, reports the first hit or length 0 */

`timescale 1ns/1ns
`default_nettype none

module fib_lookup (
    input  logic             clk,
    input  logic             rst,
    input  logic             lookup_valid,
    input  fib_pkg::prefix_t lookup_prefix,
    input  fib_pkg::plen_t   lookup_len,
    output logic             lookup_ready,
    output logic             hash_req,
    output fib_pkg::prefix_t hash_prefix,
    output fib_pkg::plen_t   hash_len,
    input  logic             hash_grant,
    input  fib_pkg::hidx_t   hash_idx,
    input  logic             hash_done,
    input  logic             hash_done_id,
    fib_table_if.prober      tbl,
    output logic             lpm_valid,
    output fib_pkg::prefix_t lpm_prefix,
    output fib_pkg::plen_t   lpm_len
);
    import fib_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_HASH, S_WAIT, S_CHECK} state_t;

    state_t  state;
    prefix_t prefix_q;
    plen_t   probe_len;
    logic    accept;
    logic    own_done;

    assign lookup_ready = (state == S_IDLE) && !tbl.busy;
    assign accept       = lookup_valid && lookup_ready;

    // This block is requester 0, tag low
    assign own_done = hash_done & ~hash_done_id;

    // Hash the full prefix at the current probe length
    assign hash_req    = (state == S_HASH);
    assign hash_prefix = prefix_q;
    assign hash_len    = probe_len;

    // Table read issued with the hash result
    assign tbl.rd_en  = (state == S_WAIT) && own_done;
    assign tbl.rd_len = probe_len;
    assign tbl.rd_idx = hash_idx;

    // Result always echoes the request
    assign lpm_prefix = prefix_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            lpm_valid <= 1'b0;
        end else begin
            lpm_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Length 0 request reports at once
                    if (accept && lookup_len == '0) begin
                        lpm_valid <= 1'b1;
                    end else if (accept) begin
                        state <= S_HASH;
                    end
                end
                S_HASH: if (hash_grant) state <= S_WAIT;
                S_WAIT: if (own_done) state <= S_CHECK;
                S_CHECK: begin
                    // Hit, or last length missed
                    if (tbl.rd_hit || probe_len == plen_t'(1)) begin
                        lpm_valid <= 1'b1;
                        state     <= S_IDLE;
                    end else begin
                        state <= S_HASH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Request latch, probe length and reported length
    always_ff @(posedge clk) begin
        if (accept) begin
            prefix_q  <= lookup_prefix;
            probe_len <= lookup_len;
            lpm_len   <= '0;
        end else if (state == S_CHECK) begin
            lpm_len   <= tbl.rd_hit ? probe_len : '0;
            probe_len <= probe_len - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/fib_pkg.sv
/* FIB package: prefix, prefix length, hash index and payload byte types */

`default_nettype none

`include "fib_defines.svh"

package fib_pkg;

    // Name prefix word, MSB first
    typedef logic [`FIB_PREFIX_W-1:0] prefix_t;

    // Prefix length in bits
    // 0 means no match in lookup results
    typedef logic [`FIB_LEN_W-1:0] plen_t;

    // Column of the valid-bit table
    typedef logic [`FIB_HASH_W-1:0] hidx_t;

    // One payload byte
    typedef logic [`FIB_BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

// File: hw/fib_table.sv
/* Valid-bit table, 64 length rows by 1024 hash columns, with the post-reset
   clear sweep, one bit-set write port and one registered read port */

`timescale 1ns/1ns
`default_nettype none

`include "fib_defines.svh"

module fib_table (
    input  logic        clk,
    input  logic        rst,
    fib_table_if.memory tbl
);
    import fib_pkg::*;

    localparam int ROWS = 1 << `FIB_LEN_W;
    localparam int COLS = 1 << `FIB_HASH_W;

    // One row per prefix length
    logic [COLS-1:0] rows [ROWS];

    // Row being cleared
    plen_t clr_row;
    logic  clr_busy;

    assign tbl.busy = clr_busy;

    // Sweep control, starts at row 0 after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_busy <= 1'b1;
            clr_row  <= '0;
        end else if (clr_busy) begin
            clr_row <= clr_row + 1'b1;
            // Last row cleared this cycle
            if (clr_row == plen_t'(ROWS - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    // Memory write, sweep has the port while busy
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            rows[clr_row] <= '0;
        end else if (tbl.wr_en) begin
            rows[tbl.wr_len][tbl.wr_idx] <= 1'b1;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (tbl.rd_en) begin
            tbl.rd_hit <= rows[tbl.rd_len][tbl.rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: hw/fib_table_if.sv
/* Valid-bit table interface: learner write port, prober read port, clear status */

`timescale 1ns/1ns
`default_nettype none

interface fib_table_if;
    import fib_pkg::*;

    // Write port, sets one valid bit
    logic  wr_en;
    plen_t wr_len;
    hidx_t wr_idx;

    // Read port, hit returns one cycle after rd_en
    logic  rd_en;
    plen_t rd_len;
    hidx_t rd_idx;
    logic  rd_hit;

    // High while the table clears after reset
    logic  busy;

    // Insert controller side
    modport learner (output wr_en, wr_len, wr_idx, input busy);

    // Longest-prefix-match side
    modport prober (output rd_en, rd_len, rd_idx, input rd_hit, busy);

    // Memory side
    modport memory (input wr_en, wr_len, wr_idx, rd_en, rd_len, rd_idx,
                    output rd_hit, busy);

endinterface

`default_nettype wire

// File: hw/prefix_hash.sv
/* Shared prefix hash unit: fixed-priority arbiter for two requesters
   and one registered mask-and-fold stage */

`timescale 1ns/1ns
`default_nettype none

`include "fib_defines.svh"

module prefix_hash (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [1:0]                 req_valid,
    input  fib_pkg::prefix_t [1:0]     req_prefix,
    input  fib_pkg::plen_t [1:0]       req_len,
    output logic [1:0]                 grant,
    output fib_pkg::hidx_t             hash,
    output logic                       done,
    output logic                       done_id
);
    import fib_pkg::*;

    // Number of hash-wide chunks covering the prefix, top one zero padded
    localparam int CHUNKS = (`FIB_PREFIX_W + `FIB_HASH_W - 1) / `FIB_HASH_W;

    prefix_t sel_prefix;
    plen_t   sel_len;

    // Keep top len bits, fold 10-bit chunks, mix in the repeated length
    function automatic hidx_t fold_hash(input prefix_t p, input plen_t l);
        logic [CHUNKS*`FIB_HASH_W-1:0] wide;
        prefix_t                       mask;
        hidx_t                         acc;
        mask = ~({`FIB_PREFIX_W{1'b1}} >> l);
        wide = '0;
        wide[`FIB_PREFIX_W-1:0] = p & mask;
        // Length in 5..0, its low nibble again in 9..6
        acc = {l[3:0], l};
        for (int k = 0; k < CHUNKS; k++) begin
            acc = acc ^ wide[k*`FIB_HASH_W +: `FIB_HASH_W];
        end
        return acc;
    endfunction

    // Requester 0 (lookup) wins any tie
    assign grant[0] = req_valid[0];
    assign grant[1] = req_valid[1] & ~req_valid[0];

    // Operand mux follows the grant
    assign sel_prefix = grant[0] ? req_prefix[0] : req_prefix[1];
    assign sel_len    = grant[0] ? req_len[0]    : req_len[1];

    // Done and its tag, one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            done    <= 1'b0;
            done_id <= 1'b0;
        end else begin
            done    <= |req_valid;
            done_id <= grant[1];
        end
    end

    // Hash result register
    always_ff @(posedge clk) begin
        if (|req_valid) begin
            hash <= fold_hash(sel_prefix, sel_len);
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the FIB testbench with Verilator and run it, pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module fib_tb -f filelist.f -o fib_sim &&
./obj_dir/fib_sim | tee /dev/stderr | grep -qx "all tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/fib_tb.sv
/* FIB testbench: stimulus table of learn, lookup and data entries,
   hash and valid-bit reference model, PIT and payload source */

`timescale 1ns/1ns
`default_nettype none

`include "fib_defines.svh"

module fib_tb;
    import fib_pkg::*;

    localparam int HALF_PERIOD = 10;
    localparam int TIMEOUT     = 200;
    localparam int BURST       = `FIB_BURST_BYTES;
    localparam int N_ENTRIES   = 12;
    localparam int K_LEARN     = 0;
    localparam int K_LOOKUP    = 1;
    localparam int K_DATA      = 2;

    logic    clk = 1'b0;
    logic    rst;
    logic    learn_valid, learn_ready, lookup_valid, lookup_ready, lpm_valid;
    prefix_t learn_prefix, lookup_prefix, lpm_prefix, pit_query_prefix, data_prefix;
    plen_t   learn_len, lookup_len, lpm_len, pit_query_len, data_len;
    logic    pit_query_valid, pit_accept, pit_reject, data_valid, data_ready;
    logic    payload_valid, out_valid, burst_done;
    byte_t   payload_in, out_byte;

    // Stimulus table, one row per entry
    int      kind_tab [N_ENTRIES];
    prefix_t pfx_tab  [N_ENTRIES];
    plen_t   len_tab  [N_ENTRIES];
    logic    acc_tab  [N_ENTRIES];

    // Learned entries, one row per prefix length
    logic [(1 << `FIB_HASH_W)-1:0] model_rows [1 << `FIB_LEN_W];

    int   seed = 22588;
    int   err_count;
    logic timed_out;

    always #HALF_PERIOD clk = ~clk;

    fib uut (.*);

    // Kept bits of the prefix fold onto column b mod 10, length mixed in first
    function automatic hidx_t model_hash(input prefix_t p, input plen_t l);
        hidx_t acc;
        acc = {l[3:0], l};
        for (int b = 0; b < `FIB_PREFIX_W; b++) begin
            if (b >= `FIB_PREFIX_W - int'(l)) begin
                acc[b % `FIB_HASH_W] = acc[b % `FIB_HASH_W] ^ p[b];
            end
        end
        return acc;
    endfunction

    // Longest learned length at or below l, 0 if none
    function automatic plen_t model_lpm(input prefix_t p, input plen_t l);
        plen_t found;
        found = '0;
        for (int k = int'(l); k >= 1; k--) begin
            if (found == '0 && model_rows[k][model_hash(p, plen_t'(k))]) begin
                found = plen_t'(k);
            end
        end
        return found;
    endfunction

    // One cycle of a wait loop, flags a timeout once
    task automatic tick(input string what, inout int cnt);
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT && !timed_out) begin
            $display("Timed out waiting for %s after %0d cycles", what, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic run_learn(input prefix_t p, input plen_t l);
        int cnt;
        cnt = 0;
        while (!learn_ready && !timed_out) tick("learn_ready", cnt);
        if (timed_out) return;
        learn_valid  = 1'b1;
        learn_prefix = p;
        learn_len    = l;
        @(negedge clk);
        learn_valid = 1'b0;
        model_rows[l][model_hash(p, l)] = 1'b1;
        // Ready comes back once the bit is set
        cnt = 0;
        while (!learn_ready && !timed_out) tick("learn write", cnt);
    endtask

    task automatic run_lookup(input prefix_t p, input plen_t l);
        int    cnt;
        plen_t exp_len;
        exp_len = model_lpm(p, l);
        cnt = 0;
        while (!lookup_ready && !timed_out) tick("lookup_ready", cnt);
        if (timed_out) return;
        lookup_valid  = 1'b1;
        lookup_prefix = p;
        lookup_len    = l;
        @(negedge clk);
        lookup_valid = 1'b0;
        // Length 0 answers on the acceptance edge
        cnt = 0;
        while (!lpm_valid && !timed_out) tick("lpm_valid", cnt);
        if (timed_out) return;
        assert (lpm_len == exp_len && lpm_prefix == p) else
            report_error($sformatf("lookup got len %0d prefix %h, expected len %0d prefix %h",
                                   lpm_len, lpm_prefix, exp_len, p));
    endtask

    task automatic run_data(input prefix_t p, input plen_t l, input logic accept);
        int    cnt;
        int    sent;
        int    got;
        byte_t bytes [BURST];
        for (int k = 0; k < BURST; k++) bytes[k] = byte_t'($random(seed));
        cnt = 0;
        while (!data_ready && !timed_out) tick("data_ready", cnt);
        if (timed_out) return;
        data_valid  = 1'b1;
        data_prefix = p;
        data_len    = l;
        @(negedge clk);
        data_valid = 1'b0;
        cnt = 0;
        while (!pit_query_valid && !timed_out) tick("PIT query", cnt);
        if (timed_out) return;
        assert (pit_query_prefix == p && pit_query_len == l) else
            report_error($sformatf("PIT query %h/%0d, expected %h/%0d",
                                   pit_query_prefix, pit_query_len, p, l));
        // Single-cycle PIT answer
        pit_accept = accept;
        pit_reject = !accept;
        @(negedge clk);
        pit_accept = 1'b0;
        pit_reject = 1'b0;
        if (!accept) begin
            // Offer payload so that a wrongly started burst would show on out_valid
            payload_valid = 1'b1;
            payload_in    = bytes[0];
            cnt = 0;
            while (!data_ready && !timed_out) begin
                assert (!out_valid) else report_error("out_valid after PIT reject");
                tick("data_ready after reject", cnt);
            end
            assert (!out_valid) else report_error("out_valid after PIT reject");
            payload_valid = 1'b0;
            return;
        end
        sent = 0;
        got  = 0;
        cnt  = 0;
        while (got < BURST && !timed_out) begin
            if (out_valid) begin
                assert (out_byte == bytes[got] && burst_done == (got == BURST - 1)) else
                    report_error($sformatf("byte %0d is %h done %b, expected %h",
                                           got, out_byte, burst_done, bytes[got]));
                got++;
            end else begin
                assert (!burst_done) else report_error("burst_done without a byte");
            end
            assert (!pit_query_valid) else report_error("second PIT query during burst");
            // Gap in payload_valid every fourth cycle
            if (sent < BURST && cnt % 4 != 2) begin
                payload_valid = 1'b1;
                payload_in    = bytes[sent];
                sent++;
            end else begin
                payload_valid = 1'b0;
            end
            tick("payload output", cnt);
        end
        payload_valid = 1'b0;
    endtask

    task automatic add_entry(input int idx, input int k, input prefix_t p, input plen_t l,
                             input logic a);
        kind_tab[idx] = k;
        pfx_tab[idx]  = p;
        len_tab[idx]  = l;
        acc_tab[idx]  = a;
    endtask

    initial begin
        prefix_t pa, pb, pc, pd, pe;
        int      errs_before;
        int      n_pass;
        int      n_fail;
        string   kind_name;
        rst = 1'b1;
        {learn_valid, lookup_valid, data_valid, pit_accept, pit_reject} = '0;
        {learn_prefix, lookup_prefix, data_prefix} = '0;
        {learn_len, lookup_len, data_len} = '0;
        payload_valid = 1'b0;
        payload_in    = '0;
        err_count = 0;
        n_pass    = 0;
        n_fail    = 0;
        timed_out = 1'b0;
        foreach (model_rows[r]) model_rows[r] = '0;
        pa = {$random(seed), $random(seed)};
        pb = {$random(seed), $random(seed)};
        pd = {$random(seed), $random(seed)};
        pe = {$random(seed), $random(seed)};
        // Complement of the first name, so no learned prefix of it matches
        pc = ~pa;
        add_entry(0, K_LOOKUP, pa, 6'd40, 1'b0);
        add_entry(1, K_LEARN, pa, 6'd8, 1'b0);
        add_entry(2, K_LEARN, pa, 6'd20, 1'b0);
        add_entry(3, K_LOOKUP, pa, 6'd40, 1'b0);
        add_entry(4, K_LOOKUP, pa, 6'd12, 1'b0);
        add_entry(5, K_LEARN, pb, 6'd33, 1'b0);
        add_entry(6, K_LOOKUP, pb, 6'd33, 1'b0);
        add_entry(7, K_LOOKUP, pc, 6'd50, 1'b0);
        add_entry(8, K_LOOKUP, pa, 6'd0, 1'b0);
        add_entry(9, K_DATA, pd, 6'd24, 1'b1);
        add_entry(10, K_DATA, pe, 6'd12, 1'b0);
        add_entry(11, K_DATA, pb, 6'd33, 1'b1);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // Outputs quiet and both request streams blocked by the clear sweep
        errs_before = err_count;
        assert (!lpm_valid && !pit_query_valid && !out_valid && !burst_done &&
                !learn_ready && !lookup_ready) else report_error("outputs active after reset");
        if (err_count == errs_before) n_pass++;
        else n_fail++;
        $display("reset: %s", (err_count == errs_before) ? "PASS" : "FAIL");
        for (int i = 0; i < N_ENTRIES && !timed_out; i++) begin
            errs_before = err_count;
            case (kind_tab[i])
                K_LEARN:  run_learn(pfx_tab[i], len_tab[i]);
                K_LOOKUP: run_lookup(pfx_tab[i], len_tab[i]);
                default:  run_data(pfx_tab[i], len_tab[i], acc_tab[i]);
            endcase
            kind_name = (kind_tab[i] == K_LEARN) ? "learn" :
                        (kind_tab[i] == K_LOOKUP) ? "lookup" : "data";
            if (err_count == errs_before && !timed_out) n_pass++;
            else n_fail++;
            $display("entry %0d %s len %0d: %s", i, kind_name, len_tab[i],
                     (err_count == errs_before && !timed_out) ? "PASS" : "FAIL");
        end
        $display("%0d passed, %0d failed, %0d errors", n_pass, n_fail, err_count);
        if (n_fail == 0 && err_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
